// ==== gecko_core.sv ====
`include "gecko_settings.svh"

module gecko_core
    import gecko_pkg::*;
(
    input  wire                            clk,
    input  wire                            rst_n,

    input  wire                            instruction_valid,
    output logic                           instruction_ready,
    input  wire  [`GECKO_XLEN-1:0]         instruction_data,
    input  wire  [`GECKO_XLEN-1:0]         instruction_pc,

    output logic                           result_valid,
    input  wire                            result_ready,
    output logic [`GECKO_REG_BITS-1:0]     result_rd,
    output logic [`GECKO_XLEN-1:0]         result_value,
    output logic [`GECKO_XLEN-1:0]         result_pc,

    output logic [`GECKO_COUNT_WIDTH-1:0]  retired_count,
    output logic                           exit_flag,
    output logic                           error_flag
);

    logic                         issue_valid;
    logic                         issue_ready;
    gecko_issue_t                 issue_data;

    logic                         exec_valid;
    logic                         exec_ready;
    gecko_result_t                exec_data;

    logic                         wb_write;
    logic [`GECKO_REG_BITS-1:0]   wb_rd;
    logic [`GECKO_XLEN-1:0]       wb_value;
    logic                         wb_clear;
    logic [`GECKO_REG_BITS-1:0]   wb_clear_rd;
    logic                         halted;

    gecko_decode i_gecko_decode (
        .clk,
        .rst_n,
        .instruction_valid,
        .instruction_ready,
        .instruction_data,
        .instruction_pc,
        .issue_valid,
        .issue_ready,
        .issue_data,
        .wb_write,
        .wb_rd,
        .wb_value,
        .wb_clear,
        .wb_clear_rd,
        .halted
    );

    gecko_execute i_gecko_execute (
        .clk,
        .rst_n,
        .issue_valid,
        .issue_ready,
        .issue_data,
        .exec_valid,
        .exec_ready,
        .exec_data
    );

    gecko_writeback i_gecko_writeback (
        .clk,
        .rst_n,
        .exec_valid,
        .exec_ready,
        .exec_data,
        .result_valid,
        .result_ready,
        .result_rd,
        .result_value,
        .result_pc,
        .wb_write,
        .wb_rd,
        .wb_value,
        .wb_clear,
        .wb_clear_rd,
        .halted,
        .retired_count,
        .exit_flag,
        .error_flag
    );

endmodule

// ==== gecko_decode.sv ====
`include "gecko_settings.svh"

module gecko_decode
    import gecko_pkg::*;
(
    input  wire                          clk,
    input  wire                          rst_n,

    input  wire                          instruction_valid,
    output logic                         instruction_ready,
    input  wire  [`GECKO_XLEN-1:0]       instruction_data,
    input  wire  [`GECKO_XLEN-1:0]       instruction_pc,

    output logic                         issue_valid,
    input  wire                          issue_ready,
    output gecko_issue_t                 issue_data,

    input  wire                          wb_write,
    input  wire  [`GECKO_REG_BITS-1:0]   wb_rd,
    input  wire  [`GECKO_XLEN-1:0]       wb_value,

    input  wire                          wb_clear,
    input  wire  [`GECKO_REG_BITS-1:0]   wb_clear_rd,

    input  wire                          halted
);

    localparam logic [6:0] OPCODE_OP     = 7'b0110011;
    localparam logic [6:0] OPCODE_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPCODE_LUI    = 7'b0110111;
    localparam logic [6:0] OPCODE_SYSTEM = 7'b1110011;
    localparam logic [`GECKO_XLEN-1:0] ECALL_WORD = 32'h0000_0073;

    logic [`GECKO_XLEN-1:0]      regs [`GECKO_REG_COUNT];
    logic [`GECKO_REG_COUNT-1:0] pending;
    logic [`GECKO_REG_COUNT-1:0] pending_now;
    logic                        stopped;

    logic [6:0]                  opcode;
    logic [2:0]                  funct3;
    logic [6:0]                  funct7;
    logic [`GECKO_REG_BITS-1:0]  rs1;
    logic [`GECKO_REG_BITS-1:0]  rs2;
    logic [`GECKO_REG_BITS-1:0]  rd;
    logic [`GECKO_XLEN-1:0]      imm_i;
    logic [`GECKO_XLEN-1:0]      imm_u;
    logic [`GECKO_XLEN-1:0]      rs1_value;
    logic [`GECKO_XLEN-1:0]      rs2_value;

    gecko_op_kind_t              kind;
    gecko_alu_op_t               alu_op;
    logic [`GECKO_XLEN-1:0]      operand_b;
    logic                        use_rs1;
    logic                        use_rs2;
    logic                        dest_write;
    logic                        hazard;
    logic                        can_issue;
    logic                        stage_ready;
    logic                        accept;
    gecko_issue_t                next_issue;

    always_comb begin
        opcode = instruction_data[6:0];
        rd     = instruction_data[11:7];
        funct3 = instruction_data[14:12];
        rs1    = instruction_data[19:15];
        rs2    = instruction_data[24:20];
        funct7 = instruction_data[31:25];
        imm_i  = {{20{instruction_data[31]}}, instruction_data[31:20]};
        imm_u  = {instruction_data[31:12], 12'b0};
    end

    // Reads see the value writeback stores in this same cycle
    always_comb begin
        rs1_value = regs[rs1];
        rs2_value = regs[rs2];
        if (wb_write && wb_rd == rs1) rs1_value = wb_value;
        if (wb_write && wb_rd == rs2) rs2_value = wb_value;
        if (rs1 == '0) rs1_value = '0;
        if (rs2 == '0) rs2_value = '0;
    end

    always_comb begin
        kind      = OP_KIND_ILLEGAL;
        alu_op    = ALU_ADD;
        operand_b = imm_i;
        use_rs1   = 1'b0;
        use_rs2   = 1'b0;
        case (opcode)
            OPCODE_OP: begin
                kind      = OP_KIND_ALU;
                use_rs1   = 1'b1;
                use_rs2   = 1'b1;
                operand_b = rs2_value;
                case ({funct7, funct3})
                    10'b0000000_000: alu_op = ALU_ADD;
                    10'b0100000_000: alu_op = ALU_SUB;
                    10'b0000000_001: alu_op = ALU_SLL;
                    10'b0000000_010: alu_op = ALU_SLT;
                    10'b0000000_011: alu_op = ALU_SLTU;
                    10'b0000000_100: alu_op = ALU_XOR;
                    10'b0000000_101: alu_op = ALU_SRL;
                    10'b0100000_101: alu_op = ALU_SRA;
                    10'b0000000_110: alu_op = ALU_OR;
                    10'b0000000_111: alu_op = ALU_AND;
                    default:         kind   = OP_KIND_ILLEGAL;
                endcase
            end
            OPCODE_OP_IMM: begin
                kind    = OP_KIND_ALU;
                use_rs1 = 1'b1;
                case (funct3)
                    3'b000: alu_op = ALU_ADD;
                    3'b010: alu_op = ALU_SLT;
                    3'b011: alu_op = ALU_SLTU;
                    3'b100: alu_op = ALU_XOR;
                    3'b110: alu_op = ALU_OR;
                    3'b111: alu_op = ALU_AND;
                    3'b001: begin
                        alu_op = ALU_SLL;
                        if (funct7 != 7'b0000000) kind = OP_KIND_ILLEGAL;
                    end
                    default: begin
                        alu_op = funct7[5] ? ALU_SRA : ALU_SRL;
                        if ((funct7 & 7'b1011111) != 7'b0) kind = OP_KIND_ILLEGAL;
                    end
                endcase
            end
            OPCODE_LUI: begin
                kind      = OP_KIND_ALU;
                alu_op    = ALU_PASS_B;
                operand_b = imm_u;
            end
            OPCODE_SYSTEM: begin
                if (instruction_data == ECALL_WORD) kind = OP_KIND_EXIT;
            end
            default: kind = OP_KIND_ILLEGAL;
        endcase
    end

    always_comb dest_write = kind == OP_KIND_ALU && rd != '0;

    // A retiring write frees its register in the same cycle
    always_comb begin
        pending_now = pending;
        if (wb_clear) pending_now[wb_clear_rd] = 1'b0;
    end

    // The rd check keeps two writes to one register from racing a reader
    always_comb begin
        hazard = (use_rs1 && pending_now[rs1]) ||
                 (use_rs2 && pending_now[rs2]) ||
                 (dest_write && pending_now[rd]);
    end

    always_comb can_issue = instruction_valid && !stopped && !halted && !hazard;
    always_comb instruction_ready = stage_ready && !stopped && !halted && !hazard;
    always_comb accept = can_issue && stage_ready;

    always_comb begin
        next_issue.kind      = kind;
        next_issue.alu_op    = alu_op;
        next_issue.operand_a = rs1_value;
        next_issue.operand_b = operand_b;
        next_issue.rd        = (kind == OP_KIND_ALU) ? rd : '0;
        next_issue.pc        = instruction_pc;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pending <= '0;
            stopped <= 1'b0;
        end else begin
            pending <= pending_now;
            if (accept && dest_write) pending[rd] <= 1'b1; // Wins over a clear of the same rd
            if (accept && kind != OP_KIND_ALU) stopped <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (wb_write) begin
            regs[wb_rd] <= wb_value;
        end
    end

    gecko_stream_reg #(.T(gecko_issue_t)) i_issue_reg (
        .clk,
        .rst_n,
        .in_valid  (can_issue),
        .in_ready  (stage_ready),
        .in_data   (next_issue),
        .out_valid (issue_valid),
        .out_ready (issue_ready),
        .out_data  (issue_data)
    );

endmodule

// ==== gecko_execute.sv ====
`include "gecko_settings.svh"

module gecko_execute
    import gecko_pkg::*;
(
    input  wire            clk,
    input  wire            rst_n,

    input  wire            issue_valid,
    output logic           issue_ready,
    input  gecko_issue_t   issue_data,

    output logic           exec_valid,
    input  wire            exec_ready,
    output gecko_result_t  exec_data
);

    localparam int SHIFT_BITS = $clog2(`GECKO_XLEN);

    logic [`GECKO_XLEN-1:0]  a;
    logic [`GECKO_XLEN-1:0]  b;
    logic [SHIFT_BITS-1:0]   shamt;
    logic                    less_signed;
    logic                    less_unsigned;
    logic [`GECKO_XLEN-1:0]  alu_value;
    gecko_result_t           result;

    always_comb begin
        a             = issue_data.operand_a;
        b             = issue_data.operand_b;
        shamt         = b[SHIFT_BITS-1:0]; // Only the low five bits shift
        less_signed   = $signed(a) < $signed(b);
        less_unsigned = a < b;
    end

    always_comb begin
        case (issue_data.alu_op)
            ALU_ADD:    alu_value = a + b;
            ALU_SUB:    alu_value = a - b;
            ALU_SLL:    alu_value = a << shamt;
            ALU_SLT:    alu_value = {{(`GECKO_XLEN-1){1'b0}}, less_signed};
            ALU_SLTU:   alu_value = {{(`GECKO_XLEN-1){1'b0}}, less_unsigned};
            ALU_XOR:    alu_value = a ^ b;
            ALU_SRL:    alu_value = a >> shamt;
            ALU_SRA:    alu_value = $signed(a) >>> shamt;
            ALU_OR:     alu_value = a | b;
            ALU_AND:    alu_value = a & b;
            ALU_PASS_B: alu_value = b;
            default:    alu_value = '0;
        endcase
    end

    always_comb begin
        result.kind  = issue_data.kind;
        result.rd    = issue_data.rd;
        result.value = (issue_data.kind == OP_KIND_ALU) ? alu_value : '0;
        result.pc    = issue_data.pc;
    end

    gecko_stream_reg #(.T(gecko_result_t)) i_result_reg (
        .clk,
        .rst_n,
        .in_valid  (issue_valid),
        .in_ready  (issue_ready),
        .in_data   (result),
        .out_valid (exec_valid),
        .out_ready (exec_ready),
        .out_data  (exec_data)
    );

endmodule

// ==== gecko_pkg.sv ====
`include "gecko_settings.svh"

package gecko_pkg;

    // What the result module does with a beat
    typedef enum logic [1:0] {
        OP_KIND_ALU     = 2'd0,
        OP_KIND_EXIT    = 2'd1,
        OP_KIND_ILLEGAL = 2'd2
    } gecko_op_kind_t;

    typedef enum logic [3:0] {
        ALU_ADD    = 4'd0,
        ALU_SUB    = 4'd1,
        ALU_SLL    = 4'd2,
        ALU_SLT    = 4'd3,
        ALU_SLTU   = 4'd4,
        ALU_XOR    = 4'd5,
        ALU_SRL    = 4'd6,
        ALU_SRA    = 4'd7,
        ALU_OR     = 4'd8,
        ALU_AND    = 4'd9,
        ALU_PASS_B = 4'd10 // LUI hands its immediate straight through
    } gecko_alu_op_t;

    typedef struct packed {
        gecko_op_kind_t              kind;
        gecko_alu_op_t               alu_op;
        logic [`GECKO_XLEN-1:0]      operand_a;
        logic [`GECKO_XLEN-1:0]      operand_b;
        logic [`GECKO_REG_BITS-1:0]  rd;
        logic [`GECKO_XLEN-1:0]      pc;
    } gecko_issue_t;

    typedef struct packed {
        gecko_op_kind_t              kind;
        logic [`GECKO_REG_BITS-1:0]  rd;
        logic [`GECKO_XLEN-1:0]      value; // Zero for EXIT and ILLEGAL
        logic [`GECKO_XLEN-1:0]      pc;
    } gecko_result_t;

endpackage

// ==== gecko_settings.svh ====
`ifndef GECKO_SETTINGS_SVH
`define GECKO_SETTINGS_SVH

// Width of data words, addresses and instruction words
`define GECKO_XLEN 32

// Architectural integer registers, x0 included
`define GECKO_REG_COUNT 32

// Width of a register index
`define GECKO_REG_BITS 5

// Width of the retired instruction counter
`define GECKO_COUNT_WIDTH 16

`endif

// ==== gecko_stream_reg.sv ====
module gecko_stream_reg #(
    parameter type T = logic
) (
    input  wire   clk,
    input  wire   rst_n,

    input  wire   in_valid,
    output logic  in_ready,
    input  T      in_data,

    output logic  out_valid,
    input  wire   out_ready,
    output T      out_data
);

    // Space is free when empty or when the held beat leaves this cycle
    always_comb in_ready = !out_valid || out_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else if (in_ready) begin
            out_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            out_data <= in_data;
        end
    end

endmodule

// ==== gecko_tb.sv ====
`include "gecko_settings.svh"

module gecko_tb;

    logic                           clk;
    logic                           rst_n;
    logic                           restart;
    logic                           instruction_valid;
    logic                           instruction_ready;
    logic [`GECKO_XLEN-1:0]         instruction_data;
    logic [`GECKO_XLEN-1:0]         instruction_pc;
    logic                           result_valid;
    logic                           result_ready;
    logic [`GECKO_REG_BITS-1:0]     result_rd;
    logic [`GECKO_XLEN-1:0]         result_value;
    logic [`GECKO_XLEN-1:0]         result_pc;
    logic [`GECKO_COUNT_WIDTH-1:0]  retired_count;
    logic                           exit_flag;
    logic                           error_flag;

    integer                         seed;
    logic                           random_stall;
    logic [`GECKO_XLEN-1:0]         model_regs [`GECKO_REG_COUNT];
    logic [`GECKO_XLEN-1:0]         next_pc;
    logic [`GECKO_COUNT_WIDTH-1:0]  total_sent;
    logic [`GECKO_XLEN-1:0]         prog_word [$];
    logic [`GECKO_XLEN-1:0]         prog_pc [$];
    logic [`GECKO_REG_BITS-1:0]     exp_rd [$];
    logic [`GECKO_XLEN-1:0]         exp_value [$];
    logic [`GECKO_XLEN-1:0]         exp_pc [$];

    gecko_tb_clock i_gecko_tb_clock (.restart, .clk, .rst_n);

    gecko_core i_gecko_core (
        .clk,
        .rst_n,
        .instruction_valid,
        .instruction_ready,
        .instruction_data,
        .instruction_pc,
        .result_valid,
        .result_ready,
        .result_rd,
        .result_value,
        .result_pc,
        .retired_count,
        .exit_flag,
        .error_flag
    );

    task automatic stop_with_error(input string msg);
        $display("%s", msg);
        $display("Finished with errors");
        $fatal(1);
    endtask

    task automatic check_field(input string name, input logic [`GECKO_XLEN-1:0] got,
                               input logic [`GECKO_XLEN-1:0] expected);
        if (got !== expected) begin
            stop_with_error($sformatf("Error: %s is %h, expected %h", name, got, expected));
        end
    endtask

    task automatic compare_result(input logic [`GECKO_REG_BITS-1:0] rd,
                                  input logic [`GECKO_XLEN-1:0] value,
                                  input logic [`GECKO_XLEN-1:0] pc);
        if (exp_rd.size() == 0) begin
            stop_with_error("A result beat arrived when no result was expected");
        end else begin
            check_field("result_rd", rd, exp_rd.pop_front());
            check_field("result_value", value, exp_value.pop_front());
            check_field("result_pc", pc, exp_pc.pop_front());
        end
    endtask

    task automatic compare_flags(input logic exit_expected, input logic error_expected,
                                 input logic [`GECKO_COUNT_WIDTH-1:0] count_expected);
        check_field("exit_flag", exit_flag, exit_expected);
        check_field("error_flag", error_flag, error_expected);
        check_field("retired_count", retired_count, count_expected);
    endtask

    function automatic logic [31:0] op_word(input logic [6:0] funct7, input logic [2:0] funct3,
                                            input logic [4:0] rd, input logic [4:0] rs1,
                                            input logic [4:0] rs2);
        return {funct7, rs2, rs1, funct3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] op_imm_word(input logic [11:0] imm, input logic [2:0] funct3,
                                                input logic [4:0] rd, input logic [4:0] rs1);
        return {imm, rs1, funct3, rd, 7'b0010011};
    endfunction

    function automatic logic [31:0] lui_word(input logic [19:0] imm, input logic [4:0] rd);
        return {imm, rd, 7'b0110111};
    endfunction

    // Reference model runs each word as it is queued, following the RV32I rules
    task automatic push_instruction(input logic [`GECKO_XLEN-1:0] word);
        logic [`GECKO_XLEN-1:0] a;
        logic [`GECKO_XLEN-1:0] b;
        logic [`GECKO_XLEN-1:0] value;
        logic [4:0]             sh;
        prog_word.push_back(word);
        prog_pc.push_back(next_pc);
        a = model_regs[word[19:15]];
        b = (word[6:0] == 7'b0110011) ? model_regs[word[24:20]] : {{20{word[31]}}, word[31:20]};
        sh = b[4:0];
        case (word[14:12])
            3'd0: value = (word[6:0] == 7'b0110011 && word[30]) ? a - b : a + b;
            3'd1: value = a << sh;
            3'd2: value = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3: value = (a < b) ? 32'd1 : 32'd0;
            3'd4: value = a ^ b;
            3'd5: begin
                if (word[30]) value = $signed(a) >>> sh;
                else value = a >> sh;
            end
            3'd6: value = a | b;
            default: value = a & b;
        endcase
        if (word[6:0] == 7'b0110111) value = {word[31:12], 12'h000};
        if (word[6:0] inside {7'b0110011, 7'b0010011, 7'b0110111}) begin
            exp_rd.push_back(word[11:7]);
            exp_value.push_back(value);
            exp_pc.push_back(next_pc);
            if (word[11:7] != 5'd0) model_regs[word[11:7]] = value; // x0 stays zero
        end
        next_pc = next_pc + 4;
        total_sent = total_sent + 1'b1;
    endtask

    task automatic load_random(input logic [4:0] rd);
        logic [`GECKO_XLEN-1:0] r;
        r = $random(seed);
        push_instruction(lui_word(r[31:12], rd));
        r = $random(seed);
        push_instruction(op_imm_word(r[11:0], 3'd0, rd, rd));
    endtask

    // Streams the queued words in and checks results until every expected result arrived
    task automatic run_program();
        integer cycles;
        integer stretch;
        logic   ready_level;
        cycles = 0;
        stretch = 0;
        ready_level = 1'b1;
        while (prog_word.size() != 0 || exp_rd.size() != 0 || instruction_valid) begin
            @(negedge clk);
            if (random_stall && stretch == 0) begin
                ready_level = $random(seed) & 1;
                stretch = ($random(seed) & 7) + 1;
            end
            if (stretch > 0) stretch = stretch - 1;
            result_ready = random_stall ? ready_level : 1'b1;
            instruction_valid = prog_word.size() != 0;
            if (instruction_valid) begin
                instruction_data = prog_word[0];
                instruction_pc = prog_pc[0];
            end
            #1;
            if (instruction_valid && instruction_ready) begin
                void'(prog_word.pop_front());
                void'(prog_pc.pop_front());
            end
            if (result_valid && result_ready) compare_result(result_rd, result_value, result_pc);
            cycles = cycles + 1;
            if (cycles > 3000) stop_with_error("Timeout while the program was running");
        end
    endtask

    // Polls until a flag rises while any result beat counts as unexpected
    task automatic wait_for_halt();
        integer cycles;
        cycles = 0;
        while (exit_flag !== 1'b1 && error_flag !== 1'b1) begin
            @(negedge clk);
            #1;
            if (result_valid) compare_result(result_rd, result_value, result_pc);
            cycles = cycles + 1;
            if (cycles > 50) stop_with_error("Timeout while waiting for a flag to rise");
        end
    endtask

    task automatic wait_reset_release();
        integer cycles;
        cycles = 0;
        while (rst_n !== 1'b1) begin
            @(negedge clk);
            #1;
            cycles = cycles + 1;
            if (cycles > 20) stop_with_error("Reset was never released");
        end
    endtask

    task automatic test_reset_and_lui();
        check_field("result_valid", result_valid, 1'b0);
        compare_flags(1'b0, 1'b0, '0);
        push_instruction(lui_word(20'h12345, 5'd1));
        push_instruction(op_imm_word(12'h678, 3'd0, 5'd1, 5'd1));
        push_instruction(op_imm_word(12'h801, 3'd0, 5'd2, 5'd1));
        run_program();
    endtask

    task automatic test_alu_functions();
        int                     round;
        int                     f;
        logic [`GECKO_XLEN-1:0] r;
        for (round = 0; round < 4; round++) begin
            load_random(5'd1);
            load_random(5'd2);
            for (f = 0; f < 8; f++) begin
                r = $random(seed);
                push_instruction(op_word(7'h00, f[2:0], 5'(8 + f), 5'd1, 5'd2));
                if (f == 0 || f == 5) begin
                    push_instruction(op_word(7'h20, f[2:0], 5'(24 + f), 5'd1, 5'd2));
                end
                if (f == 1 || f == 5) r[11:5] = 7'h00; // Shift immediates carry only shamt
                push_instruction(op_imm_word(r[11:0], f[2:0], 5'(16 + f), 5'd1));
                if (f == 5) push_instruction(op_imm_word({7'h20, r[4:0]}, 3'd5, 5'd30, 5'd1));
            end
            run_program();
        end
    endtask

    task automatic test_dependencies();
        load_random(5'd6);
        push_instruction(op_imm_word(12'h001, 3'd0, 5'd7, 5'd6));
        push_instruction(op_word(7'h00, 3'd0, 5'd7, 5'd7, 5'd6));
        push_instruction(op_word(7'h20, 3'd0, 5'd8, 5'd7, 5'd6));
        push_instruction(op_word(7'h00, 3'd4, 5'd6, 5'd8, 5'd7));
        push_instruction(op_imm_word(12'h055, 3'd0, 5'd0, 5'd6));
        push_instruction(op_word(7'h00, 3'd6, 5'd9, 5'd0, 5'd6));
        push_instruction(op_imm_word(12'h7ff, 3'd7, 5'd10, 5'd0));
        run_program();
    endtask

    task automatic test_back_pressure();
        int                     i;
        logic [`GECKO_XLEN-1:0] r;
        random_stall = 1'b1;
        load_random(5'd11);
        load_random(5'd12);
        for (i = 0; i < 16; i++) begin
            r = $random(seed);
            push_instruction(op_imm_word(r[11:0], 3'd4, 5'(13 + i % 3), 5'd11));
            push_instruction(op_word(7'h00, 3'd0, 5'd12, 5'd12, 5'(13 + i % 3)));
        end
        run_program();
        random_stall = 1'b0;
    endtask

    task automatic test_ecall();
        push_instruction(op_imm_word(12'h123, 3'd0, 5'd14, 5'd0));
        push_instruction(32'h0000_0073);
        run_program();
        wait_for_halt();
        compare_flags(1'b1, 1'b0, total_sent);
        repeat (8) begin
            @(negedge clk);
            instruction_valid = 1'b1;
            instruction_data = op_imm_word(12'h001, 3'd0, 5'd15, 5'd0);
            #1;
            if (instruction_ready) stop_with_error("instruction_ready rose after ECALL retired");
        end
        @(negedge clk);
        instruction_valid = 1'b0;
    endtask

    task automatic test_illegal_after_reset();
        @(negedge clk);
        restart = 1'b1;
        #1;
        wait_reset_release();
        restart = 1'b0;
        total_sent = '0;
        next_pc = '0;
        check_field("result_valid", result_valid, 1'b0);
        compare_flags(1'b0, 1'b0, '0);
        push_instruction(32'hffff_ffff);
        run_program();
        wait_for_halt(); // Any result beat here fails in compare_result
        compare_flags(1'b0, 1'b1, 16'd1);
    endtask

    initial begin
        seed = 57;
        restart = 1'b0;
        random_stall = 1'b0;
        instruction_valid = 1'b0;
        instruction_data = '0;
        instruction_pc = '0;
        result_ready = 1'b1;
        next_pc = '0;
        total_sent = '0;
        foreach (model_regs[i]) model_regs[i] = '0;
        wait_reset_release();
        test_reset_and_lui();
        test_alu_functions();
        test_dependencies();
        test_back_pressure();
        test_ecall();
        test_illegal_after_reset();
        $display("Finished with no errors");
        $finish;
    end

endmodule

// ==== gecko_tb_clock.sv ====
module gecko_tb_clock (
    input  wire   restart,
    output logic  clk,
    output logic  rst_n
);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Reset holds for four cycles and lets go on a falling edge
    initial begin
        rst_n = 1'b0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        forever begin
            @(posedge restart);
            rst_n = 1'b0;
            repeat (4) @(posedge clk);
            @(negedge clk);
            rst_n = 1'b1;
        end
    end

endmodule

// ==== gecko_writeback.sv ====
`include "gecko_settings.svh"

module gecko_writeback
    import gecko_pkg::*;
(
    input  wire                            clk,
    input  wire                            rst_n,

    input  wire                            exec_valid,
    output logic                           exec_ready,
    input  gecko_result_t                  exec_data,

    output logic                           result_valid,
    input  wire                            result_ready,
    output logic [`GECKO_REG_BITS-1:0]     result_rd,
    output logic [`GECKO_XLEN-1:0]         result_value,
    output logic [`GECKO_XLEN-1:0]         result_pc,

    output logic                           wb_write,
    output logic [`GECKO_REG_BITS-1:0]     wb_rd,
    output logic [`GECKO_XLEN-1:0]         wb_value,
    output logic                           wb_clear,
    output logic [`GECKO_REG_BITS-1:0]     wb_clear_rd,

    output logic                           halted,
    output logic [`GECKO_COUNT_WIDTH-1:0]  retired_count,
    output logic                           exit_flag,
    output logic                           error_flag
);

    logic is_alu;
    logic transfer;

    always_comb is_alu = exec_data.kind == OP_KIND_ALU;
    always_comb result_valid = exec_valid && is_alu;
    always_comb exec_ready = is_alu ? result_ready : 1'b1; // Flag beats never wait
    always_comb transfer = exec_valid && exec_ready;

    always_comb result_rd = exec_data.rd;
    always_comb result_value = exec_data.value;
    always_comb result_pc = exec_data.pc;

    // x0 is reported on the stream but never written
    always_comb wb_write = transfer && is_alu && exec_data.rd != '0;
    always_comb wb_rd = exec_data.rd;
    always_comb wb_value = exec_data.value;
    always_comb wb_clear = wb_write;
    always_comb wb_clear_rd = exec_data.rd;

    always_comb halted = exit_flag || error_flag;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            retired_count <= '0;
            exit_flag     <= 1'b0;
            error_flag    <= 1'b0;
        end else if (transfer) begin
            retired_count <= retired_count + 1'b1;
            if (exec_data.kind == OP_KIND_EXIT) exit_flag <= 1'b1;
            if (exec_data.kind == OP_KIND_ILLEGAL) error_flag <= 1'b1;
        end
    end

endmodule

// ==== project.f ====
+incdir+.
gecko_pkg.sv
gecko_stream_reg.sv
gecko_decode.sv
gecko_execute.sv
gecko_writeback.sv
gecko_core.sv
gecko_tb_clock.sv
gecko_tb.sv
